/* design/mbxPkg.sv */
// Shared word, source, data-code and diagnostic-phase types for the MB control core
`default_nettype none

package mbxPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Memory buffer geometry
  ////////////////////////////////////////////////////////////////////////////

  // Four words, addressed by two bits
  localparam int MB_WORDS = 4;

  // One bit per MB word, bit n for word n
  typedef logic [MB_WORDS-1:0] wordMaskT;

  // Number of an MB word
  typedef logic [1:0] wordIndexT;

  ////////////////////////////////////////////////////////////////////////////
  // MB input source and stored data code
  ////////////////////////////////////////////////////////////////////////////

  // Encoded as the MB IN SEL 4/2/1 lines
  typedef enum logic [2:0] {
    SRC_CACHE = 3'b000,
    SRC_AR    = 3'b010,
    SRC_CHAN  = 3'b011,
    SRC_MEM   = 3'b100,
    SRC_CCW   = 3'b110
  } mbSourceT;

  // Who last wrote a word into the buffer
  typedef enum logic [1:0] {
    CODE_NONE = 2'd0,
    CODE_MEM  = 2'd1,
    CODE_EBOX = 2'd2,
    CODE_CHAN = 2'd3
  } mbDataCodeT;

  ////////////////////////////////////////////////////////////////////////////
  // SBUS diagnostic cycle
  ////////////////////////////////////////////////////////////////////////////

  localparam int DIAG_PHASES = 4;

  // Phase 0 to 3 of the diagnostic SBUS cycle
  typedef logic [1:0] diagPhaseT;

endpackage

`default_nettype wire

/* design/mbWordRequests.sv */
// Pending-word register with lowest-word priority select and select hold, used by mbControl
`default_nettype none
`timescale 1ns/1ns

module mbWordRequests (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire logic             loadRequests,
  input  wire mbxPkg::wordMaskT needMask,
  input  wire logic             clearSelected,
  output mbxPkg::wordIndexT     mbSel,
  output logic                  anyRequest,
  output logic                  mbSelHold,
  output mbxPkg::wordMaskT      pending
);

  import mbxPkg::*;

  wordMaskT  clearMask;
  wordMaskT  loadMask;
  wordIndexT prioSel;
  wordIndexT heldSel;
  logic      holdFf;

  ////////////////////////////////////////////////////////////////////////////
  // Pending-word register
  ////////////////////////////////////////////////////////////////////////////

  // Bit of the selected word while a clear is in progress
  always_comb begin
    clearMask = '0;
    if (clearSelected) begin
      clearMask = wordMaskT'(1) << mbSel;
    end
  end

  assign loadMask = loadRequests ? needMask : '0;

  // Clear goes first, so a word cleared and reloaded on one edge stays pending
  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clearMask) | loadMask;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Priority select and hold
  ////////////////////////////////////////////////////////////////////////////

  // Lowest-numbered pending word wins and an idle register gives word 0
  always_comb begin
    prioSel = '0;
    for (int i = MB_WORDS - 1; i >= 0; i--) begin
      if (pending[i]) begin
        prioSel = wordIndexT'(i);
      end
    end
  end

  assign anyRequest = |pending;

  // Drops during the clear cycle so the next word can be picked afterwards
  assign mbSelHold = anyRequest & ~clearSelected;

  always_ff @(posedge clk) begin
    if (reset) begin
      holdFf <= 1'b0;
    end else begin
      holdFf <= mbSelHold;
    end
  end

  // Tracks the word on the select lines until the hold flop freezes it
  always_ff @(posedge clk) begin
    heldSel <= mbSel;
  end

  // A newly loaded lower word waits until the held one is cleared
  assign mbSel = holdFf ? heldSel : prioSel;

endmodule

`default_nettype wire

/* design/mbWordStatus.sv */
// Per-word parity and data-code store with readout at the selected MB word, used by mbControl
`default_nettype none
`timescale 1ns/1ns

module mbWordStatus (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              storeWord,
  input  wire logic              parIn,
  input  wire mbxPkg::mbSourceT  source,
  input  wire mbxPkg::wordIndexT mbSel,
  output logic                   mbPar,
  output mbxPkg::mbDataCodeT     mbDataCode
);

  import mbxPkg::*;

  logic       parBits [MB_WORDS];
  mbDataCodeT codes   [MB_WORDS];
  mbDataCodeT codeIn;

  // Unused source encodings store no code
  function automatic mbDataCodeT toDataCode(input mbSourceT src);
    mbDataCodeT code;
    case (src)
      SRC_MEM:  code = CODE_MEM;
      SRC_CACHE,
      SRC_AR:   code = CODE_EBOX;
      SRC_CHAN,
      SRC_CCW:  code = CODE_CHAN;
      default:  code = CODE_NONE;
    endcase
    return code;
  endfunction

  assign codeIn = toDataCode(source);

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // Data codes start out empty
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < MB_WORDS; i++) begin
        codes[i] <= CODE_NONE;
      end
    end else if (storeWord) begin
      codes[mbSel] <= codeIn;
    end
  end

  // Parity travels with the word data
  always_ff @(posedge clk) begin
    if (storeWord) begin
      parBits[mbSel] <= parIn;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Readout
  ////////////////////////////////////////////////////////////////////////////

  // Four-way read mux on the select lines
  always_comb begin
    mbPar      = parBits[mbSel];
    mbDataCode = codes[mbSel];
  end

endmodule

`default_nettype wire

/* design/cacheToMbSequencer.sv */
// T1 to T4 cache-to-MB writeback sequencer paced by the memory phase pulse, used by mbControl
`default_nettype none
`timescale 1ns/1ns

module cacheToMbSequencer (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic writebackStart,
  input  wire logic anyRequest,
  input  wire logic phaseChangeComing,
  output logic      cacheToMbBusy,
  output logic      cacheToMbDone,
  output logic      memWrRq
);

  // State encodings
  localparam logic [2:0] IDLE = 3'd0;
  localparam logic [2:0] T1   = 3'd1;
  localparam logic [2:0] T2   = 3'd2;
  localparam logic [2:0] T3   = 3'd3;
  localparam logic [2:0] T4   = 3'd4;

  logic [2:0] state;
  logic [2:0] stateNext;

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    stateNext = state;
    case (state)
      IDLE: begin
        if (writebackStart) begin
          stateNext = T1;
        end
      end
      // Another word to move or the writeback is finished
      T1: begin
        if (anyRequest) begin
          stateNext = T2;
        end else begin
          stateNext = IDLE;
        end
      end
      // Wait here for the memory phase change
      T2: begin
        if (phaseChangeComing) begin
          stateNext = T3;
        end
      end
      T3: begin
        stateNext = T4;
      end
      // Word goes to memory and the loop returns for the next one
      T4: begin
        stateNext = T1;
      end
      default: begin
        stateNext = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= stateNext;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign cacheToMbBusy = (state != IDLE);

  // One T1 cycle with nothing left in the buffer
  assign cacheToMbDone = (state == T1) & ~anyRequest;

  // Also clears the selected word at the top level
  assign memWrRq = (state == T4);

endmodule

`default_nettype wire

/* design/sbusDiagCounter.sv */
// Four-phase SBUS diagnostic cycle counter with its memory strobes, used by mbControl
`default_nettype none
`timescale 1ns/1ns

module sbusDiagCounter (
  input  wire logic         clk,
  input  wire logic         reset,
  input  wire logic         sbusDiagStart,
  input  wire logic         aChangeComing,
  output logic              sbusDiagCyc,
  output mbxPkg::diagPhaseT diagPhase,
  output logic              memDiag,
  output logic              memDataToMem,
  output logic              diagDone
);

  import mbxPkg::*;

  localparam diagPhaseT LAST_PHASE = diagPhaseT'(DIAG_PHASES - 1);

  logic      active;
  diagPhaseT phase;

  // A-change in the last phase closes the cycle
  assign diagDone = active & aChangeComing & (phase == LAST_PHASE);

  ////////////////////////////////////////////////////////////////////////////
  // Active flag and phase counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
      phase  <= '0;
    end else if (!active) begin
      // Start is only taken between cycles
      if (sbusDiagStart) begin
        active <= 1'b1;
        phase  <= '0;
      end
    end else if (aChangeComing) begin
      if (diagDone) begin
        active <= 1'b0;
        phase  <= '0;
      end else begin
        phase <= phase + diagPhaseT'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Phase decode
  ////////////////////////////////////////////////////////////////////////////

  assign sbusDiagCyc = active;
  assign diagPhase   = phase;

  // Diagnostic function goes out in phase 0
  assign memDiag = active & (phase == '0);

  // Data drives toward memory in phases 0 and 1
  assign memDataToMem = active & ~phase[1];

endmodule

`default_nettype wire

/* design/mbControl.sv */
// Top level of the MB control core, wiring request, status, sequencer and diagnostic blocks
`default_nettype none
`timescale 1ns/1ns

module mbControl (
  input  wire logic              clk,
  input  wire logic              reset,

  // Word requests
  input  wire logic              loadRequests,
  input  wire mbxPkg::wordMaskT  needMask,
  input  wire logic              wordDone,
  output mbxPkg::wordIndexT      mbSel,
  output logic                   anyRequest,
  output logic                   mbSelHold,
  output mbxPkg::wordMaskT       pendingWords,

  // Word status
  input  wire logic              storeWord,
  input  wire logic              parIn,
  input  wire mbxPkg::mbSourceT  source,
  output logic                   mbPar,
  output mbxPkg::mbDataCodeT     mbDataCode,

  // Cache to MB writeback
  input  wire logic              writebackStart,
  input  wire logic              phaseChangeComing,
  output logic                   cacheToMbBusy,
  output logic                   cacheToMbDone,
  output logic                   memWrRq,

  // SBUS diagnostic cycle
  input  wire logic              sbusDiagStart,
  input  wire logic              aChangeComing,
  output logic                   sbusDiagCyc,
  output mbxPkg::diagPhaseT      diagPhase,
  output logic                   memDiag,
  output logic                   memDataToMem,
  output logic                   diagDone
);

  logic clearSelected;

  ////////////////////////////////////////////////////////////////////////////
  // Word clear merge
  ////////////////////////////////////////////////////////////////////////////

  // Either an outside word completion or the sequencer's T4 step
  assign clearSelected = wordDone | memWrRq;

  ////////////////////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////////////////////

  mbWordRequests u_wordRequests (
    .clk           (clk),
    .reset         (reset),
    .loadRequests  (loadRequests),
    .needMask      (needMask),
    .clearSelected (clearSelected),
    .mbSel         (mbSel),
    .anyRequest    (anyRequest),
    .mbSelHold     (mbSelHold),
    .pending       (pendingWords)
  );

  // Status is written and read at the same selected word
  mbWordStatus u_wordStatus (
    .clk        (clk),
    .reset      (reset),
    .storeWord  (storeWord),
    .parIn      (parIn),
    .source     (source),
    .mbSel      (mbSel),
    .mbPar      (mbPar),
    .mbDataCode (mbDataCode)
  );

  cacheToMbSequencer u_sequencer (
    .clk               (clk),
    .reset             (reset),
    .writebackStart    (writebackStart),
    .anyRequest        (anyRequest),
    .phaseChangeComing (phaseChangeComing),
    .cacheToMbBusy     (cacheToMbBusy),
    .cacheToMbDone     (cacheToMbDone),
    .memWrRq           (memWrRq)
  );

  sbusDiagCounter u_diagCounter (
    .clk           (clk),
    .reset         (reset),
    .sbusDiagStart (sbusDiagStart),
    .aChangeComing (aChangeComing),
    .sbusDiagCyc   (sbusDiagCyc),
    .diagPhase     (diagPhase),
    .memDiag       (memDiag),
    .memDataToMem  (memDataToMem),
    .diagDone      (diagDone)
  );

endmodule

`default_nettype wire

/* tb/mbControlTb.sv */
// Directed testbench for mbControl, run as the simulation top with the design files in list.f
`default_nettype none
`timescale 1ns/1ns

module mbControlTb;

  import mbxPkg::*;

  localparam int CLK_HALF     = 50;
  localparam int DRIVE_DELAY  = 5;
  localparam int RESET_CYCLES = 8;
  localparam int RAND_CYCLES  = 200;
  // Reset, request, status, writeback and diagnostic tests plus a margin
  localparam int TEST_CYCLES    = RESET_CYCLES + 2 + RAND_CYCLES + 30 + MB_WORDS * 18
                                  + MB_WORDS * 8 + 10 + DIAG_PHASES * 5 + 2;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES + 100;

  logic       clk, reset, loadRequests, wordDone, storeWord, parIn;
  logic       writebackStart, phaseChangeComing, sbusDiagStart, aChangeComing;
  wordMaskT   needMask, pendingWords;
  mbSourceT   source;
  wordIndexT  mbSel;
  logic       anyRequest, mbSelHold, mbPar;
  mbDataCodeT mbDataCode;
  logic       cacheToMbBusy, cacheToMbDone, memWrRq;
  logic       sbusDiagCyc, memDiag, memDataToMem, diagDone;
  diagPhaseT  diagPhase;

  logic [31:0] lfsrState;
  wordMaskT    pendModel;
  wordIndexT   selModel;
  int          errorCount, checksRun, testsRun, cycleCount, wrCount, doneCount, startErrors;

  mbControl u_mbControl (.*);

  always #CLK_HALF clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("The run timed out after %0d cycles before all tests were done", cycleCount);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // Counts write requests and done strobes in the middle of each cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (memWrRq === 1'b1) wrCount++;
      if (cacheToMbDone === 1'b1) doneCount++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random bits and reference rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  // One LFSR step per bit
  function automatic logic [7:0] randBits(input int count);
    logic [7:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrStep(lfsrState);
      bits = {bits[6:0], lfsrState[0]};
    end
    return bits;
  endfunction

  function automatic wordIndexT lowestWord(input wordMaskT mask);
    int idx;
    idx = 0;
    if (mask == '0) return '0;
    while (!mask[idx]) begin
      idx++;
    end
    return wordIndexT'(idx);
  endfunction

  // Source encoding to data code
  function automatic mbDataCodeT expectedCode(input logic [2:0] src);
    case (src)
      3'b100:         return CODE_MEM;
      3'b000, 3'b010: return CODE_EBOX;
      3'b011, 3'b110: return CODE_CHAN;
      default:        return CODE_NONE;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkMask(input wordMaskT actual, input wordMaskT expected, input string what);
    checksRun++;
    if (actual !== expected) begin
      errorCount++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic checkIndex(input wordIndexT actual, input wordIndexT expected,
                            input string what);
    checksRun++;
    if (actual !== expected) begin
      errorCount++;
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic checkCode(input mbDataCodeT actual, input mbDataCodeT expected,
                           input string what);
    checksRun++;
    if (actual !== expected) begin
      errorCount++;
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic checkPhase(input diagPhaseT actual, input diagPhaseT expected,
                            input string what);
    checksRun++;
    if (actual !== expected) begin
      errorCount++;
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic checkBit(input logic actual, input logic expected, input string what);
    checksRun++;
    if (actual !== expected) begin
      errorCount++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic checkCount(input int actual, input int expected, input string what);
    checksRun++;
    if (actual != expected) begin
      errorCount++;
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Cycle helpers
  ////////////////////////////////////////////////////////////////////////////

  // Pulse inputs fall back low every cycle
  task automatic driveEdge();
    @(posedge clk);
    #DRIVE_DELAY;
    loadRequests      = 1'b0;
    wordDone          = 1'b0;
    storeWord         = 1'b0;
    writebackStart    = 1'b0;
    phaseChangeComing = 1'b0;
    sbusDiagStart     = 1'b0;
    aChangeComing     = 1'b0;
  endtask

  task automatic midCycle();
    @(negedge clk);
  endtask

  // One cycle of loads and clears, checked against the pending-word model
  task automatic requestCycle(input logic load, input wordMaskT mask, input logic done);
    wordMaskT nextPend;
    driveEdge();
    loadRequests = load;
    needMask     = mask;
    wordDone     = done;
    midCycle();
    checkMask(pendingWords, pendModel, "pending words");
    checkBit(anyRequest, |pendModel, "any request");
    checkIndex(mbSel, selModel, "selected word");
    checkBit(mbSelHold, (|pendModel) & ~done, "select hold");
    nextPend = pendModel;
    if (done) nextPend[selModel] = 1'b0;
    if (load) nextPend = nextPend | mask;
    // Selection is kept while words wait and none is being cleared
    if (!((|pendModel) && !done)) selModel = lowestWord(nextPend);
    pendModel = nextPend;
  endtask

  task automatic drainRequests();
    while (pendModel != '0) begin
      requestCycle(1'b0, '0, 1'b1);
    end
    requestCycle(1'b0, '0, 1'b0);
  endtask

  task automatic diagOutputs(input int phase, input logic done);
    checkBit(sbusDiagCyc, 1'b1, "diagnostic cycle");
    checkPhase(diagPhase, diagPhaseT'(phase), "diagnostic phase");
    checkBit(memDiag, phase == 0, "memory diagnostic strobe");
    checkBit(memDataToMem, phase < 2, "data to memory strobe");
    checkBit(diagDone, done, "diagnostic done");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic resetTest();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    midCycle();
    checkBit(memWrRq, 1'b0, "write request after reset");
    checkBit(cacheToMbBusy, 1'b0, "busy after reset");
    checkBit(cacheToMbDone, 1'b0, "done after reset");
    checkBit(sbusDiagCyc, 1'b0, "diagnostic cycle after reset");
    checkBit(memDiag, 1'b0, "memory diagnostic after reset");
    checkBit(memDataToMem, 1'b0, "data to memory after reset");
    checkBit(diagDone, 1'b0, "diagnostic done after reset");
    checkBit(anyRequest, 1'b0, "any request after reset");
    checkBit(mbSelHold, 1'b0, "select hold after reset");
    checkIndex(mbSel, '0, "selected word after reset");
    checkMask(pendingWords, '0, "pending words after reset");
    checkCode(mbDataCode, CODE_NONE, "data code after reset");
  endtask

  task automatic requestTest();
    logic     load;
    logic     done;
    wordMaskT mask;
    for (int i = 0; i < RAND_CYCLES; i++) begin
      load = (randBits(2) == 8'd0);
      mask = wordMaskT'(randBits(4));
      done = 1'(randBits(1));
      requestCycle(load, mask, done);
    end
    drainRequests();
    // Word 3 held while word 0 arrives
    requestCycle(1'b1, 4'b1000, 1'b0);
    requestCycle(1'b0, '0, 1'b0);
    requestCycle(1'b1, 4'b0001, 1'b0);
    requestCycle(1'b0, '0, 1'b0);
    checkIndex(mbSel, 2'd3, "held word against a lower load");
    requestCycle(1'b0, '0, 1'b1);
    requestCycle(1'b0, '0, 1'b0);
    checkIndex(mbSel, 2'd0, "next word after the held one");
    requestCycle(1'b0, '0, 1'b1);
    // Load and clear of word 2 on one edge
    requestCycle(1'b1, 4'b0100, 1'b0);
    requestCycle(1'b1, 4'b0101, 1'b1);
    requestCycle(1'b0, '0, 1'b0);
    checkMask(pendingWords, 4'b0101, "clear and load on one edge");
    drainRequests();
  endtask

  task automatic statusTest();
    logic par;
    for (int w = 0; w < MB_WORDS; w++) begin
      requestCycle(1'b1, wordMaskT'(1) << w, 1'b0);
      for (int s = 0; s < 8; s++) begin
        par = 1'(randBits(1));
        driveEdge();
        storeWord = 1'b1;
        parIn     = par;
        source    = mbSourceT'(3'(s));
        midCycle();
        checkIndex(mbSel, wordIndexT'(w), "word selected for store");
        driveEdge();
        midCycle();
        checkBit(mbPar, par, "parity readback");
        checkCode(mbDataCode, expectedCode(3'(s)), "data code readback");
      end
      requestCycle(1'b0, '0, 1'b1);
    end
  endtask

  task automatic writebackTest();
    wordMaskT mask;
    int       words, wrBefore, doneBefore, delay;
    mask = wordMaskT'(randBits(4));
    if (mask == '0) mask = 4'b1010;
    words      = $countones(mask);
    wrBefore   = wrCount;
    doneBefore = doneCount;
    requestCycle(1'b1, mask, 1'b0);
    driveEdge();
    writebackStart = 1'b1;
    midCycle();
    checkBit(cacheToMbBusy, 1'b0, "busy before start");
    driveEdge();
    midCycle();
    checkBit(cacheToMbBusy, 1'b1, "busy in first T1");
    for (int k = 0; k < words; k++) begin
      delay = randBits(2);
      repeat (delay) begin
        driveEdge();
        midCycle();
        checkBit(memWrRq, 1'b0, "write request while waiting for phase");
      end
      driveEdge();
      phaseChangeComing = 1'b1;
      midCycle();
      checkBit(memWrRq, 1'b0, "write request in the phase pulse cycle");
      driveEdge();
      midCycle();
      checkBit(memWrRq, 1'b0, "write request one cycle after phase");
      driveEdge();
      midCycle();
      checkBit(memWrRq, 1'b1, "write request two cycles after phase");
      checkIndex(mbSel, lowestWord(pendModel), "word written back");
      pendModel[lowestWord(pendModel)] = 1'b0;
      driveEdge();
      midCycle();
      checkBit(cacheToMbBusy, 1'b1, "busy back in T1");
      checkMask(pendingWords, pendModel, "pending after write");
    end
    checkBit(cacheToMbDone, 1'b1, "done after the last word");
    driveEdge();
    midCycle();
    checkBit(cacheToMbBusy, 1'b0, "busy after done");
    checkBit(cacheToMbDone, 1'b0, "done after one cycle");
    selModel = '0;
    // Nothing pending
    driveEdge();
    writebackStart = 1'b1;
    driveEdge();
    midCycle();
    checkBit(cacheToMbDone, 1'b1, "done with nothing pending");
    checkBit(memWrRq, 1'b0, "write request with nothing pending");
    driveEdge();
    midCycle();
    checkBit(cacheToMbBusy, 1'b0, "busy after empty writeback");
    checkCount(wrCount - wrBefore, words, "write requests");
    checkCount(doneCount - doneBefore, 2, "done strobes");
  endtask

  task automatic diagTest();
    int gap;
    driveEdge();
    sbusDiagStart = 1'b1;
    midCycle();
    checkBit(sbusDiagCyc, 1'b0, "diagnostic cycle before start");
    for (int p = 0; p < DIAG_PHASES; p++) begin
      gap = 1 + randBits(2);
      for (int g = 0; g < gap; g++) begin
        driveEdge();
        // A second start in phase 1 must not restart the cycle
        if (p == 1 && g == 0) sbusDiagStart = 1'b1;
        midCycle();
        diagOutputs(p, 1'b0);
      end
      driveEdge();
      aChangeComing = 1'b1;
      midCycle();
      diagOutputs(p, p == DIAG_PHASES - 1);
    end
    driveEdge();
    midCycle();
    checkBit(sbusDiagCyc, 1'b0, "diagnostic cycle after done");
    checkBit(memDataToMem, 1'b0, "data to memory after done");
  endtask

  task automatic endTest(input string name, input int errorsBefore);
    testsRun++;
    $display("%s test finished with %0d errors", name, errorCount - errorsBefore);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    loadRequests = 1'b0;
    needMask = '0;
    wordDone = 1'b0;
    storeWord = 1'b0;
    parIn = 1'b0;
    source = SRC_CACHE;
    writebackStart = 1'b0;
    phaseChangeComing = 1'b0;
    sbusDiagStart = 1'b0;
    aChangeComing = 1'b0;
    lfsrState = 32'h770d;
    pendModel = '0;
    selModel = '0;
    errorCount = 0;
    checksRun = 0;
    testsRun = 0;
    cycleCount = 0;
    wrCount = 0;
    doneCount = 0;
    startErrors = errorCount;
    resetTest();
    endTest("Reset", startErrors);
    startErrors = errorCount;
    requestTest();
    endTest("Request tracking", startErrors);
    startErrors = errorCount;
    statusTest();
    endTest("Word status", startErrors);
    startErrors = errorCount;
    writebackTest();
    endTest("Cache to MB", startErrors);
    startErrors = errorCount;
    diagTest();
    endTest("Diagnostic cycle", startErrors);
    $display("Tests %0d, checks %0d, errors %0d", testsRun, checksRun, errorCount);
    if (errorCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
design/mbxPkg.sv
design/mbWordRequests.sv
design/mbWordStatus.sv
design/cacheToMbSequencer.sv
design/sbusDiagCounter.sv
design/mbControl.sv
tb/mbControlTb.sv
